/* logic/msm_pkg.sv */
package msm_pkg;

  ////////////////////
  // Sizes
  ////////////////////
  // Default accumulator count, the top level starts from this
  localparam int NUM_ACCU  = 2;
  localparam int NUM_WIN   = 2;
  localparam int WIN_W     = 3;
  // Digit 0 selects no bucket
  localparam int NUM_BKT   = (1 << WIN_W) - 1;
  localparam int WIN_IDX_W = 1;
  localparam int PNT_W     = 16;
  localparam int ACC_ID_W  = 1;

  ////////////////////
  // Types
  ////////////////////
  typedef logic [PNT_W-1:0] pnt_t;

  // Group modulus, a 16-bit prime
  localparam pnt_t P_MOD = 16'd65521;

  typedef logic [NUM_WIN-1:0][WIN_W-1:0] red_scal_t;

  // Slice i goes to accumulator i
  typedef red_scal_t [NUM_ACCU-1:0] scal_word_t;

  typedef struct packed {
    logic       last;
    scal_word_t word;
  } scal_beat_t;

  typedef struct packed {
    logic clear_bkt;
    logic write_bkt;
  } mode_t;

  typedef struct packed {
    logic [ACC_ID_W-1:0]  acc_id;
    logic [WIN_IDX_W-1:0] win;
    logic [WIN_W-1:0]     digit;
    pnt_t                 value;
    logic                 last;
  } bucket_beat_t;

endpackage : msm_pkg

/* logic/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     ap_clk_i,
  input  logic     arst_n_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != FULL_CNT);
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge ap_clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, so any depth works
  always_ff @(posedge ap_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule : stream_fifo

/* logic/scalar_splitter.sv */
`timescale 1ns/1ps

module scalar_splitter #(
  parameter int NUM_ACCU = msm_pkg::NUM_ACCU
) (
  input  logic                              ap_clk_i,
  input  logic                              arst_n_i,
  input  msm_pkg::scal_beat_t               scal_i,
  input  logic                              valid_i,
  output logic                              ready_o,
  output msm_pkg::red_scal_t [NUM_ACCU-1:0] red_scal_o,
  output logic [NUM_ACCU-1:0]               last_o,
  output logic [NUM_ACCU-1:0]               valid_o,
  input  logic [NUM_ACCU-1:0]               ready_i
);

  // Lanes that already took the current word
  logic [NUM_ACCU-1:0] taken_q;
  logic [NUM_ACCU-1:0] accept;

  for (genvar i = 0; i < NUM_ACCU; i++) begin : g_lane
    assign red_scal_o[i] = scal_i.word[i];
    assign last_o[i]     = scal_i.last;
  end

  assign valid_o = {NUM_ACCU{valid_i}} & ~taken_q;
  assign accept  = valid_o & ready_i;

  // Word leaves when the last pending lane accepts
  assign ready_o = &(taken_q | ready_i);

  always_ff @(posedge ap_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      taken_q <= '0;
    end else if (valid_i) begin
      if (ready_o) begin
        taken_q <= '0;
      end else begin
        taken_q <= taken_q | accept;
      end
    end
  end

endmodule : scalar_splitter

/* logic/bucket_accumulator.sv */
`timescale 1ns/1ps

module bucket_accumulator #(
  parameter int ACC_ID = 0
) (
  input  logic                  ap_clk_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  msm_pkg::mode_t        mode_i,
  input  msm_pkg::red_scal_t    red_scal_i,
  input  logic                  red_scal_last_i,
  input  logic                  red_scal_valid_i,
  output logic                  red_scal_ready_o,
  input  msm_pkg::pnt_t         pnt_i,
  input  logic                  pnt_valid_i,
  output logic                  pnt_ready_o,
  output logic                  done_o,
  output msm_pkg::bucket_beat_t bucket_o,
  output logic                  bucket_valid_o,
  input  logic                  bucket_ready_i
);

  localparam int NUM_WIN   = msm_pkg::NUM_WIN;
  localparam int NUM_BKT   = msm_pkg::NUM_BKT;
  localparam int WIN_W     = msm_pkg::WIN_W;
  localparam int WIN_IDX_W = msm_pkg::WIN_IDX_W;
  localparam int PNT_W     = msm_pkg::PNT_W;

  // Bucket b of a window holds digit b+1
  msm_pkg::pnt_t        bkt_q [NUM_WIN][NUM_BKT];
  logic                 running_q;
  logic                 writing_q;
  logic                 done_q;
  logic [WIN_IDX_W-1:0] wr_win_q;
  logic [WIN_W-1:0]     wr_dig_q;
  logic                 take_en;
  logic                 fire;
  logic                 fire_last;
  logic                 wr_fire;
  logic                 wr_last;

  // Inputs are below P_MOD, so one subtraction is enough
  function automatic msm_pkg::pnt_t mod_add(msm_pkg::pnt_t a, msm_pkg::pnt_t b);
    logic [PNT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    if (sum >= {1'b0, msm_pkg::P_MOD}) begin
      sum = sum - {1'b0, msm_pkg::P_MOD};
    end
    return sum[PNT_W-1:0];
  endfunction

  ////////////////////
  // Input join
  ////////////////////
  assign take_en          = running_q && !writing_q;
  assign red_scal_ready_o = take_en && pnt_valid_i;
  assign pnt_ready_o      = take_en && red_scal_valid_i;
  assign fire             = take_en && red_scal_valid_i && pnt_valid_i;
  assign fire_last        = fire && red_scal_last_i;

  always_ff @(posedge ap_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < NUM_WIN; w++) begin
        for (int b = 0; b < NUM_BKT; b++) begin
          bkt_q[w][b] <= '0;
        end
      end
    end else if (start_i && mode_i.clear_bkt) begin
      for (int w = 0; w < NUM_WIN; w++) begin
        for (int b = 0; b < NUM_BKT; b++) begin
          bkt_q[w][b] <= '0;
        end
      end
    end else if (fire) begin
      for (int w = 0; w < NUM_WIN; w++) begin
        if (red_scal_i[w] != '0) begin
          bkt_q[w][red_scal_i[w] - 1'b1] <= mod_add(bkt_q[w][red_scal_i[w] - 1'b1], pnt_i);
        end
      end
    end
  end

  ////////////////////
  // Write-out
  ////////////////////
  assign wr_fire = writing_q && bucket_ready_i;
  assign wr_last = (wr_win_q == WIN_IDX_W'(NUM_WIN - 1)) && (wr_dig_q == WIN_W'(NUM_BKT));

  always_comb begin
    bucket_o.acc_id = ACC_ID[msm_pkg::ACC_ID_W-1:0];
    bucket_o.win    = wr_win_q;
    bucket_o.digit  = wr_dig_q;
    bucket_o.value  = bkt_q[wr_win_q][wr_dig_q - 1'b1];
    bucket_o.last   = wr_last;
  end

  assign bucket_valid_o = writing_q;
  assign done_o         = done_q;

  always_ff @(posedge ap_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running_q <= 1'b0;
      writing_q <= 1'b0;
      done_q    <= 1'b0;
      wr_win_q  <= '0;
      wr_dig_q  <= '0;
    end else begin
      done_q <= fire_last;
      if (start_i) begin
        running_q <= 1'b1;
      end else if (fire_last) begin
        running_q <= 1'b0;
      end
      if (fire_last && mode_i.write_bkt) begin
        writing_q <= 1'b1;
        wr_win_q  <= '0;
        wr_dig_q  <= WIN_W'(1);
      end else if (wr_fire) begin
        if (wr_last) begin
          writing_q <= 1'b0;
        end else if (wr_dig_q == WIN_W'(NUM_BKT)) begin
          wr_dig_q <= WIN_W'(1);
          wr_win_q <= wr_win_q + 1'b1;
        end else begin
          wr_dig_q <= wr_dig_q + 1'b1;
        end
      end
    end
  end

endmodule : bucket_accumulator

/* logic/bucket_wr_scheduler.sv */
`timescale 1ns/1ps

module bucket_wr_scheduler #(
  parameter int NUM_ACCU = msm_pkg::NUM_ACCU
) (
  input  logic                                 ap_clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 start_i,
  input  msm_pkg::bucket_beat_t [NUM_ACCU-1:0] bucket_i,
  input  logic [NUM_ACCU-1:0]                  valid_i,
  output logic [NUM_ACCU-1:0]                  ready_o,
  output msm_pkg::bucket_beat_t                bucket_o,
  output logic                                 valid_o,
  input  logic                                 ready_i,
  output logic                                 wr_done_o
);

  localparam int IDX_W = (NUM_ACCU > 1) ? $clog2(NUM_ACCU) : 1;

  logic                busy_q;
  logic [IDX_W-1:0]    grant_q;
  logic [IDX_W-1:0]    last_q;
  logic [NUM_ACCU-1:0] pending_q;
  logic                wr_done_q;
  logic [IDX_W-1:0]    pick_idx;
  logic                pick_found;
  logic [NUM_ACCU-1:0] grant_mask;
  logic                fire_last;

  // Round robin, search starts after the last served accumulator
  always_comb begin
    int idx;
    pick_found = 1'b0;
    pick_idx   = last_q;
    for (int k = 1; k <= NUM_ACCU; k++) begin
      idx = (int'(last_q) + k) % NUM_ACCU;
      if (!pick_found && valid_i[idx]) begin
        pick_found = 1'b1;
        pick_idx   = IDX_W'(idx);
      end
    end
  end

  always_comb begin
    grant_mask          = '0;
    grant_mask[grant_q] = 1'b1;
  end

  // Granted stream passes straight through
  assign bucket_o  = bucket_i[grant_q];
  assign valid_o   = busy_q && valid_i[grant_q];
  assign ready_o   = busy_q ? (grant_mask & {NUM_ACCU{ready_i}}) : '0;
  assign fire_last = valid_o && ready_i && bucket_o.last;
  assign wr_done_o = wr_done_q;

  always_ff @(posedge ap_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      grant_q   <= '0;
      last_q    <= IDX_W'(NUM_ACCU - 1);
      pending_q <= '0;
      wr_done_q <= 1'b0;
    end else begin
      wr_done_q <= 1'b0;
      if (!busy_q) begin
        if (pick_found) begin
          busy_q  <= 1'b1;
          grant_q <= pick_idx;
        end
      end else if (fire_last) begin
        // Hold the grant until the whole bucket set has passed
        busy_q    <= 1'b0;
        last_q    <= grant_q;
        wr_done_q <= ((pending_q & grant_mask) != '0) && ((pending_q & ~grant_mask) == '0);
      end
      if (start_i) begin
        pending_q <= '1;
      end else if (fire_last) begin
        pending_q <= pending_q & ~grant_mask;
      end
    end
  end

endmodule : bucket_wr_scheduler

/* logic/run_ctrl.sv */
`timescale 1ns/1ps

module run_ctrl #(
  parameter int NUM_ACCU = msm_pkg::NUM_ACCU
) (
  input  logic                ap_clk_i,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  msm_pkg::mode_t      mode_i,
  input  logic [NUM_ACCU-1:0] accu_done_i,
  input  logic                wr_done_i,
  output logic                start_o,
  output msm_pkg::mode_t      mode_o,
  output logic                idle_o,
  output logic                done_o
);

  logic                start_q;
  logic                idle_q;
  msm_pkg::mode_t      mode_q;
  logic [NUM_ACCU-1:0] sticky_q;
  logic                all_done_q;
  logic [NUM_ACCU-1:0] seen;
  logic                launch;

  assign launch = start_i && idle_o;
  assign seen   = sticky_q | accu_done_i;

  // Write mode waits for the scheduler
  assign done_o  = mode_q.write_bkt ? wr_done_i : all_done_q;
  assign idle_o  = idle_q || done_o;
  assign start_o = start_q;
  assign mode_o  = mode_q;

  always_ff @(posedge ap_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q    <= 1'b0;
      idle_q     <= 1'b1;
      mode_q     <= '0;
      sticky_q   <= '0;
      all_done_q <= 1'b0;
    end else begin
      start_q    <= launch;
      all_done_q <= 1'b0;
      if (launch) begin
        idle_q <= 1'b0;
        mode_q <= mode_i;
      end else if (done_o) begin
        idle_q <= 1'b1;
      end
      // Collect done pulses, one combined pulse per run
      if (start_q) begin
        sticky_q <= '0;
      end else if (&seen) begin
        sticky_q   <= '0;
        all_done_q <= 1'b1;
      end else begin
        sticky_q <= seen;
      end
    end
  end

endmodule : run_ctrl

/* logic/msm_core.sv */
`timescale 1ns/1ps

module msm_core #(
  parameter int NUM_ACCU   = msm_pkg::NUM_ACCU,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                         ap_clk_i,
  input  logic                         arst_n_i,
  input  logic                         start_i,
  input  msm_pkg::mode_t               mode_i,
  output logic                         idle_o,
  output logic                         done_o,
  input  msm_pkg::scal_beat_t          scal_i,
  input  logic                         scal_valid_i,
  output logic                         scal_ready_o,
  input  msm_pkg::pnt_t [NUM_ACCU-1:0] pnt_i,
  input  logic [NUM_ACCU-1:0]          pnt_valid_i,
  output logic [NUM_ACCU-1:0]          pnt_ready_o,
  output msm_pkg::bucket_beat_t        bucket_o,
  output logic                         bucket_valid_o,
  input  logic                         bucket_ready_i
);

  logic                                 run_start;
  msm_pkg::mode_t                       run_mode;
  logic [NUM_ACCU-1:0]                  accu_done;
  logic                                 wr_done;

  msm_pkg::scal_beat_t                  scal_fifo;
  logic                                 scal_fifo_valid;
  logic                                 scal_fifo_ready;

  msm_pkg::red_scal_t [NUM_ACCU-1:0]    split_red_scal;
  logic [NUM_ACCU-1:0]                  split_last;
  logic [NUM_ACCU-1:0]                  split_valid;
  logic [NUM_ACCU-1:0]                  split_ready;

  msm_pkg::pnt_t [NUM_ACCU-1:0]         pnt_fifo;
  logic [NUM_ACCU-1:0]                  pnt_fifo_valid;
  logic [NUM_ACCU-1:0]                  pnt_fifo_ready;

  msm_pkg::bucket_beat_t [NUM_ACCU-1:0] accu_bucket;
  logic [NUM_ACCU-1:0]                  accu_bucket_valid;
  logic [NUM_ACCU-1:0]                  accu_bucket_ready;

  run_ctrl #(
    .NUM_ACCU(NUM_ACCU)
  ) i_run_ctrl (
    .ap_clk_i,
    .arst_n_i,
    .start_i,
    .mode_i,
    .accu_done_i(accu_done),
    .wr_done_i  (wr_done),
    .start_o    (run_start),
    .mode_o     (run_mode),
    .idle_o,
    .done_o
  );

  ////////////////////
  // Scalar path
  ////////////////////
  stream_fifo #(
    .payload_t(msm_pkg::scal_beat_t),
    .DEPTH    (FIFO_DEPTH)
  ) i_scal_fifo (
    .ap_clk_i,
    .arst_n_i,
    .data_i (scal_i),
    .valid_i(scal_valid_i),
    .ready_o(scal_ready_o),
    .data_o (scal_fifo),
    .valid_o(scal_fifo_valid),
    .ready_i(scal_fifo_ready)
  );

  scalar_splitter #(
    .NUM_ACCU(NUM_ACCU)
  ) i_scalar_splitter (
    .ap_clk_i,
    .arst_n_i,
    .scal_i    (scal_fifo),
    .valid_i   (scal_fifo_valid),
    .ready_o   (scal_fifo_ready),
    .red_scal_o(split_red_scal),
    .last_o    (split_last),
    .valid_o   (split_valid),
    .ready_i   (split_ready)
  );

  ////////////////////
  // Point path and accumulators
  ////////////////////
  for (genvar i = 0; i < NUM_ACCU; i++) begin : g_accu
    stream_fifo #(
      .payload_t(msm_pkg::pnt_t),
      .DEPTH    (FIFO_DEPTH)
    ) i_pnt_fifo (
      .ap_clk_i,
      .arst_n_i,
      .data_i (pnt_i[i]),
      .valid_i(pnt_valid_i[i]),
      .ready_o(pnt_ready_o[i]),
      .data_o (pnt_fifo[i]),
      .valid_o(pnt_fifo_valid[i]),
      .ready_i(pnt_fifo_ready[i])
    );

    bucket_accumulator #(
      .ACC_ID(i)
    ) i_bucket_accumulator (
      .ap_clk_i,
      .arst_n_i,
      .start_i         (run_start),
      .mode_i          (run_mode),
      .red_scal_i      (split_red_scal[i]),
      .red_scal_last_i (split_last[i]),
      .red_scal_valid_i(split_valid[i]),
      .red_scal_ready_o(split_ready[i]),
      .pnt_i           (pnt_fifo[i]),
      .pnt_valid_i     (pnt_fifo_valid[i]),
      .pnt_ready_o     (pnt_fifo_ready[i]),
      .done_o          (accu_done[i]),
      .bucket_o        (accu_bucket[i]),
      .bucket_valid_o  (accu_bucket_valid[i]),
      .bucket_ready_i  (accu_bucket_ready[i])
    );
  end

  bucket_wr_scheduler #(
    .NUM_ACCU(NUM_ACCU)
  ) i_bucket_wr_scheduler (
    .ap_clk_i,
    .arst_n_i,
    .start_i  (run_start),
    .bucket_i (accu_bucket),
    .valid_i  (accu_bucket_valid),
    .ready_o  (accu_bucket_ready),
    .bucket_o,
    .valid_o  (bucket_valid_o),
    .ready_i  (bucket_ready_i),
    .wr_done_o(wr_done)
  );

endmodule : msm_core

/* verif/tb_msm_core.sv */
`timescale 1ns/1ps

module tb_msm_core;

  localparam int          NUM_ACCU    = msm_pkg::NUM_ACCU;
  localparam int          NUM_WIN     = msm_pkg::NUM_WIN;
  localparam int          NUM_BKT     = msm_pkg::NUM_BKT;
  localparam int          SET_BEATS   = NUM_WIN * NUM_BKT;
  localparam int          CLK_PERIOD  = 100;
  localparam int          N_ITEMS     = 20;
  localparam int          N_RUNS      = 4;
  localparam int          WRITE_RUNS  = 3;
  localparam int          RUN_WORK    = N_ITEMS + NUM_ACCU * SET_BEATS;
  localparam int          TOTAL_WORK  = N_RUNS * N_ITEMS + WRITE_RUNS * NUM_ACCU * SET_BEATS;
  localparam int          WDOG_CYCLES = TOTAL_WORK * 20;
  localparam logic [31:0] SEED        = 32'he492_c297;

  logic                         ap_clk_i = 1'b0;
  logic                         arst_n_i;
  logic                         start_i;
  msm_pkg::mode_t               mode_i;
  logic                         idle_o;
  logic                         done_o;
  msm_pkg::scal_beat_t          scal_i;
  logic                         scal_valid_i;
  logic                         scal_ready_o;
  msm_pkg::pnt_t [NUM_ACCU-1:0] pnt_i;
  logic [NUM_ACCU-1:0]          pnt_valid_i;
  logic [NUM_ACCU-1:0]          pnt_ready_o;
  msm_pkg::bucket_beat_t        bucket_o;
  logic                         bucket_valid_o;
  logic                         bucket_ready_i;

  // Items since the last bucket clear
  // Points are stored item by item with the accumulator inside
  msm_pkg::scal_beat_t   hist_scal [$];
  msm_pkg::pnt_t         hist_pnt [$];
  logic [31:0]           rng_state;
  logic                  bp_en = 1'b0;
  int                    run_num = 0;
  int                    run_err_cnt = 0;

  // Owned by the compare process
  int                    beat_err_cnt = 0;
  int                    total_beats = 0;
  int                    done_cnt = 0;
  int                    set_pos = 0;
  int                    set_acc = 0;
  logic [NUM_ACCU-1:0]   sets_seen = '0;
  logic                  hold_q = 1'b0;
  msm_pkg::bucket_beat_t held_beat;

  always #(CLK_PERIOD / 2) ap_clk_i = ~ap_clk_i;

  msm_core #(
    .NUM_ACCU  (NUM_ACCU),
    .FIFO_DEPTH(4)
  ) i_msm_core (
    .ap_clk_i,
    .arst_n_i,
    .start_i,
    .mode_i,
    .idle_o,
    .done_o,
    .scal_i,
    .scal_valid_i,
    .scal_ready_o,
    .pnt_i,
    .pnt_valid_i,
    .pnt_ready_o,
    .bucket_o,
    .bucket_valid_o,
    .bucket_ready_i
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  // Sum modulo P_MOD of every point whose digit selects this bucket
  function automatic msm_pkg::pnt_t expect_bucket(input int acc, input int win, input int dig);
    int unsigned sum;
    sum = 0;
    for (int i = 0; i < hist_scal.size(); i++) begin
      if (32'(hist_scal[i].word[acc][win]) == dig) begin
        sum = (sum + 32'(hist_pnt[i * NUM_ACCU + acc])) % 32'(msm_pkg::P_MOD);
      end
    end
    return msm_pkg::pnt_t'(sum);
  endfunction

  task automatic gen_items(input int n);
    msm_pkg::scal_beat_t beat;
    for (int i = 0; i < n; i++) begin
      rng_state = xorshift32(rng_state);
      beat.word = rng_state[$bits(msm_pkg::scal_word_t)-1:0];
      // every fourth item carries only zero digits
      if (i % 4 == 3) begin
        beat.word = '0;
      end
      beat.last = (i == n - 1);
      hist_scal.push_back(beat);
      for (int a = 0; a < NUM_ACCU; a++) begin
        rng_state = xorshift32(rng_state);
        hist_pnt.push_back(rng_state[31:16] % msm_pkg::P_MOD);
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  // Valids rise at random and hold until the beat transfers
  task automatic feed_items(input int base, input int n);
    int                  scal_idx;
    int                  pnt_idx [NUM_ACCU];
    int                  cyc;
    logic                scal_free;
    logic [NUM_ACCU-1:0] pnt_free;
    logic                busy;
    scal_idx = 0;
    cyc      = 0;
    busy     = 1'b1;
    for (int a = 0; a < NUM_ACCU; a++) begin
      pnt_idx[a] = 0;
    end
    while (busy) begin
      @(posedge ap_clk_i);
      scal_free = !(scal_valid_i && !scal_ready_o);
      if (scal_valid_i && scal_ready_o) begin
        scal_idx++;
      end
      for (int a = 0; a < NUM_ACCU; a++) begin
        pnt_free[a] = !(pnt_valid_i[a] && !pnt_ready_o[a]);
        if (pnt_valid_i[a] && pnt_ready_o[a]) begin
          pnt_idx[a]++;
        end
      end
      @(negedge ap_clk_i);
      // The DUT must ignore a start in the middle of the run
      start_i = (cyc == 3);
      if (cyc == 3 && idle_o) begin
        $display("** Error @ %0t: idle_o high in the middle of run %0d", $time, run_num);
        run_err_cnt++;
      end
      if (scal_free) begin
        rng_state    = xorshift32(rng_state);
        scal_valid_i = (scal_idx < n) && (rng_state[1:0] != 2'b00);
        if (scal_valid_i) begin
          scal_i = hist_scal[base + scal_idx];
        end
      end
      for (int a = 0; a < NUM_ACCU; a++) begin
        if (pnt_free[a]) begin
          rng_state      = xorshift32(rng_state);
          pnt_valid_i[a] = (pnt_idx[a] < n) && (rng_state[1:0] != 2'b00);
          if (pnt_valid_i[a]) begin
            pnt_i[a] = hist_pnt[(base + pnt_idx[a]) * NUM_ACCU + a];
          end
        end
      end
      busy = (scal_idx < n);
      for (int a = 0; a < NUM_ACCU; a++) begin
        if (pnt_idx[a] < n) begin
          busy = 1'b1;
        end
      end
      cyc++;
    end
    start_i = 1'b0;
  endtask

  task automatic do_run(input logic clear, input logic write, input logic bp);
    int base;
    int done_before;
    int beats_before;
    int wait_cyc;
    int exp_beats;
    run_num++;
    if (clear) begin
      hist_scal.delete();
      hist_pnt.delete();
    end
    base = hist_scal.size();
    gen_items(N_ITEMS);
    done_before  = done_cnt;
    beats_before = total_beats;
    exp_beats    = write ? NUM_ACCU * SET_BEATS : 0;
    @(posedge ap_clk_i);
    bp_en = bp;
    @(negedge ap_clk_i);
    if (!idle_o) begin
      $display("DUT not idle before run %0d could start", run_num);
      run_err_cnt++;
    end
    mode_i.clear_bkt = clear;
    mode_i.write_bkt = write;
    start_i          = 1'b1;
    @(negedge ap_clk_i);
    start_i = 1'b0;
    if (idle_o) begin
      $display("** Error @ %0t: idle_o did not fall after start in run %0d", $time, run_num);
      run_err_cnt++;
    end
    feed_items(base, N_ITEMS);
    if (done_cnt != done_before) begin
      $display("** Error @ %0t: done_o came before all items of run %0d were fed",
               $time, run_num);
      run_err_cnt++;
    end
    wait_cyc = 0;
    while (done_cnt == done_before && wait_cyc < RUN_WORK * 20) begin
      @(negedge ap_clk_i);
      wait_cyc++;
    end
    if (done_cnt == done_before) begin
      $display("No done_o pulse came from the DUT in run %0d", run_num);
      run_err_cnt++;
    end else if (total_beats - beats_before != exp_beats) begin
      $display("** Error @ %0t: done_o came after %0d of %0d bucket beats in run %0d",
               $time, total_beats - beats_before, exp_beats, run_num);
      run_err_cnt++;
    end
    repeat (8) @(negedge ap_clk_i);
    if (done_cnt > done_before + 1) begin
      $display("** Error @ %0t: done_o pulsed %0d times in run %0d",
               $time, done_cnt - done_before, run_num);
      run_err_cnt++;
    end
    if (!idle_o) begin
      $display("** Error @ %0t: idle_o low after run %0d ended", $time, run_num);
      run_err_cnt++;
    end
    if (total_beats - beats_before != exp_beats || set_pos != 0) begin
      $display("** Error @ %0t: run %0d gave %0d bucket beats, expected %0d",
               $time, run_num, total_beats - beats_before, exp_beats);
      run_err_cnt++;
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////
  task automatic check_beat(input msm_pkg::bucket_beat_t b);
    int            w;
    int            d;
    logic          exp_last;
    msm_pkg::pnt_t exp_val;
    if (set_pos == 0) begin
      set_acc = int'(b.acc_id);
      if (sets_seen[set_acc]) begin
        $display("** Error @ %0t: second bucket set from accumulator %0d", $time, set_acc);
        beat_err_cnt++;
      end
      sets_seen[set_acc] = 1'b1;
    end
    w        = set_pos / NUM_BKT;
    d        = set_pos % NUM_BKT + 1;
    exp_last = (set_pos == SET_BEATS - 1);
    exp_val  = expect_bucket(set_acc, w, d);
    if (int'(b.acc_id) != set_acc || int'(b.win) != w || int'(b.digit) != d ||
        b.value != exp_val || b.last != exp_last) begin
      $display("** Error @ %0t: beat acc %0d win %0d digit %0d value %h last %b",
               $time, b.acc_id, b.win, b.digit, b.value, b.last);
      $display("   expected acc %0d win %0d digit %0d value %h last %b",
               set_acc, w, d, exp_val, exp_last);
      beat_err_cnt++;
    end
    set_pos = exp_last ? 0 : set_pos + 1;
    total_beats++;
  endtask

  always @(posedge ap_clk_i) begin
    if (arst_n_i) begin
      if (hold_q && (!bucket_valid_o || bucket_o !== held_beat)) begin
        $display("** Error @ %0t: bucket_o changed while waiting for ready", $time);
        beat_err_cnt++;
      end
      if (bucket_valid_o && bucket_ready_i) begin
        check_beat(bucket_o);
      end
      hold_q    = bucket_valid_o && !bucket_ready_i;
      held_beat = bucket_o;
      if (done_o) begin
        done_cnt++;
        sets_seen = '0;
        if (!idle_o) begin
          $display("** Error @ %0t: idle_o low while done_o is high", $time);
          beat_err_cnt++;
        end
      end
    end
  end

  // Ready low about three cycles in eight when back-pressure is on
  initial begin
    logic [31:0] bp_state;
    bp_state       = SEED ^ 32'h5bd1_e995;
    bucket_ready_i = 1'b1;
    forever begin
      @(negedge ap_clk_i);
      if (bp_en) begin
        bp_state       = xorshift32(bp_state);
        bucket_ready_i = (bp_state[2:0] > 3'd2);
      end else begin
        bucket_ready_i = 1'b1;
      end
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge ap_clk_i);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    logic [31:0] first_seed;
    arst_n_i     = 1'b0;
    start_i      = 1'b0;
    mode_i       = '0;
    scal_i       = '0;
    scal_valid_i = 1'b0;
    pnt_i        = '0;
    pnt_valid_i  = '0;
    rng_state    = SEED;
    repeat (4) @(negedge ap_clk_i);
    arst_n_i = 1'b1;
    @(negedge ap_clk_i);
    if (!idle_o || done_o || bucket_valid_o || !scal_ready_o || !(&pnt_ready_o)) begin
      $display("** Error @ %0t: after reset idle %b done %b bucket valid %b ready %b %b",
               $time, idle_o, done_o, bucket_valid_o, scal_ready_o, pnt_ready_o);
      run_err_cnt++;
    end
    first_seed = rng_state;
    do_run(1'b1, 1'b1, 1'b0);
    // Accumulate only, then write the sums of both runs
    do_run(1'b1, 1'b0, 1'b0);
    do_run(1'b0, 1'b1, 1'b0);
    // First run again with back-pressure on the output
    rng_state = first_seed;
    do_run(1'b1, 1'b1, 1'b1);
    $display("Runs %0d, bucket beats %0d, done pulses %0d, beat errors %0d, run errors %0d",
             run_num, total_beats, done_cnt, beat_err_cnt, run_err_cnt);
    if (beat_err_cnt == 0 && run_err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_msm_core

/* verilog.f */
logic/msm_pkg.sv
logic/stream_fifo.sv
logic/scalar_splitter.sv
logic/bucket_accumulator.sv
logic/bucket_wr_scheduler.sv
logic/run_ctrl.sv
logic/msm_core.sv
verif/tb_msm_core.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the msm_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_msm_core -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_msm_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0
